/* Makefile */
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module cache_top_tb -Mdir $(BUILD_DIR) -f verilog.f
	./$(BUILD_DIR)/Vcache_top_tb

clean:
	rm -rf $(BUILD_DIR)

/* src/cache_bank_ctrl.sv */
module cache_bank_ctrl #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush_valid,

    input  logic                                      core_req_valid,
    input  cache_msg_pkg::core_req_t                  core_req,
    output logic                                      core_req_ready,

    input  logic                                      hit,
    input  logic [cache_cfg_pkg::WORD_WIDTH-1:0]      read_word,
    output logic                                      fill_valid,
    output logic [cache_cfg_pkg::LINE_WIDTH-1:0]      fill_line,
    output logic                                      write_valid,
    output logic [cache_cfg_pkg::WORD_SIZE-1:0]       write_byteen,
    output logic [cache_cfg_pkg::WORD_WIDTH-1:0]      write_word,
    output logic [cache_cfg_pkg::WORD_ADDR_WIDTH-1:0] lookup_addr,

    output logic                                      rsp_valid,
    output cache_msg_pkg::core_rsp_t                  rsp,
    input  logic                                      rsp_ready,

    output logic                                      mreq_valid,
    output cache_msg_pkg::mem_req_t                   mreq,
    input  logic                                      mreq_ready,

    input  logic                                      mem_rsp_valid,
    input  cache_msg_pkg::mem_rsp_t                   mem_rsp
);

    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;

    if ((1 << $clog2(NUM_LINES)) != NUM_LINES) begin : g_bad_lines
        $error("NUM_LINES must be a power of two");
    end

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_miss_wait,
        st_respond
    } state_t;

    state_t                   state;
    state_t                   state_next;
    core_req_t                req_q;
    logic [WORD_SEL_BITS-1:0] wsel;
    logic                     accept;

    // Reads need room for the response, writes for the memory request
    assign core_req_ready = (state == st_idle) && !flush_valid
                          && (core_req.rw ? mreq_ready : rsp_ready);
    assign accept = core_req_valid && core_req_ready;

    assign wsel         = addr_word_sel(req_q.addr);
    assign lookup_addr  = req_q.addr;
    assign write_byteen = req_q.byteen;
    assign write_word   = req_q.data;
    assign fill_line    = mem_rsp.data;

    assign rsp = '{data: read_word, tag: req_q.tag};

    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next  = state;
        write_valid = 1'b0;
        fill_valid  = 1'b0;
        rsp_valid   = 1'b0;
        mreq_valid  = 1'b0;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (req_q.rw) begin
                    // Write through that updates the line only on a hit
                    mreq_valid  = 1'b1;
                    write_valid = hit && mreq_ready;
                    if (mreq_ready) begin
                        state_next = st_idle;
                    end
                end else if (hit) begin
                    rsp_valid  = 1'b1;
                    state_next = rsp_ready ? st_idle : st_respond;
                end else begin
                    state_next = st_miss_req;
                end
            end
            st_miss_req: begin
                mreq_valid = 1'b1;
                if (mreq_ready) begin
                    state_next = st_miss_wait;
                end
            end
            st_miss_wait: begin
                fill_valid = mem_rsp_valid;
                if (mem_rsp_valid) begin
                    state_next = st_respond;
                end
            end
            st_respond: begin
                rsp_valid = 1'b1;
                if (rsp_ready) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // Line read on a miss carries no enables
    always_comb begin
        mreq      = '0;
        mreq.rw   = req_q.rw;
        mreq.addr = addr_line(req_q.addr);
        if (req_q.rw) begin
            mreq.byteen[wsel * WORD_SIZE +: WORD_SIZE]   = req_q.byteen;
            mreq.data[wsel * WORD_WIDTH +: WORD_WIDTH]   = req_q.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= core_req;
        end
    end

endmodule

/* src/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // Word and line geometry
    localparam int WORD_SIZE         = 4;
    localparam int WORD_WIDTH        = 8 * WORD_SIZE;
    localparam int WORDS_PER_LINE    = 4;
    localparam int LINE_SIZE         = WORD_SIZE * WORDS_PER_LINE;
    localparam int LINE_WIDTH        = WORD_WIDTH * WORDS_PER_LINE;
    localparam int WORD_SEL_BITS     = $clog2(WORDS_PER_LINE);

    // Address widths in words and in lines
    localparam int WORD_ADDR_WIDTH   = 14;
    localparam int LINE_ADDR_WIDTH   = WORD_ADDR_WIDTH - WORD_SEL_BITS;

    localparam int CORE_TAG_WIDTH    = 4;
    localparam int DEFAULT_NUM_LINES = 16;

    function automatic logic [WORD_SEL_BITS-1:0] addr_word_sel(
        input logic [WORD_ADDR_WIDTH-1:0] addr
    );
        return addr[WORD_SEL_BITS-1:0];
    endfunction

    function automatic logic [LINE_ADDR_WIDTH-1:0] addr_line(
        input logic [WORD_ADDR_WIDTH-1:0] addr
    );
        return addr[WORD_ADDR_WIDTH-1:WORD_SEL_BITS];
    endfunction

    // Index and tag assume a power of two line count
    function automatic logic [LINE_ADDR_WIDTH-1:0] addr_index(
        input logic [WORD_ADDR_WIDTH-1:0] addr,
        input int unsigned                num_lines
    );
        return LINE_ADDR_WIDTH'(addr_line(addr) % num_lines);
    endfunction

    function automatic logic [LINE_ADDR_WIDTH-1:0] addr_tag(
        input logic [WORD_ADDR_WIDTH-1:0] addr,
        input int unsigned                num_lines
    );
        return LINE_ADDR_WIDTH'(addr_line(addr) / num_lines);
    endfunction

endpackage

/* src/cache_data_store.sv */
module cache_data_store #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input  logic                                      clk,
    input  logic [cache_cfg_pkg::WORD_ADDR_WIDTH-1:0] addr,
    input  logic                                      fill_valid,
    input  logic [cache_cfg_pkg::LINE_WIDTH-1:0]      fill_line,
    input  logic                                      write_valid,
    input  logic [cache_cfg_pkg::WORD_SIZE-1:0]       byteen,
    input  logic [cache_cfg_pkg::WORD_WIDTH-1:0]      write_word,
    output logic [cache_cfg_pkg::WORD_WIDTH-1:0]      read_word
);

    import cache_cfg_pkg::*;

    localparam int INDEX_W = $clog2(NUM_LINES);

    logic [LINE_WIDTH-1:0]    line_mem [NUM_LINES];
    logic [INDEX_W-1:0]       index;
    logic [WORD_SEL_BITS-1:0] wsel;

    assign index = INDEX_W'(addr_index(addr, NUM_LINES));
    assign wsel  = addr_word_sel(addr);

    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            line_mem[index] <= fill_line;
        end else if (write_valid) begin
            // Only the enabled bytes of the selected word
            for (int b = 0; b < WORD_SIZE; b++) begin
                if (byteen[b]) begin
                    line_mem[index][wsel * WORD_WIDTH + b * 8 +: 8] <= write_word[b * 8 +: 8];
                end
            end
        end
    end

    assign read_word = line_mem[index][wsel * WORD_WIDTH +: WORD_WIDTH];

endmodule

/* src/cache_flush_ctrl.sv */
module cache_flush_ctrl #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         flush_valid,
    output logic [$clog2(NUM_LINES)-1:0] flush_index
);

    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam logic [INDEX_W-1:0] LAST_INDEX = INDEX_W'(NUM_LINES - 1);

    // One line per cycle, then idle until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_valid <= 1'b1;
            flush_index <= '0;
        end else if (flush_valid) begin
            flush_index <= flush_index + INDEX_W'(1);
            if (flush_index == LAST_INDEX) begin
                flush_valid <= 1'b0;
            end
        end
    end

endmodule

/* src/cache_msg_pkg.sv */
package cache_msg_pkg;

    ////////////////////////////////////////////////////////////
    // Core side

    typedef struct packed {
        logic                                      rw;
        logic [cache_cfg_pkg::WORD_ADDR_WIDTH-1:0] addr;
        logic [cache_cfg_pkg::WORD_SIZE-1:0]       byteen;
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]      data;
        logic [cache_cfg_pkg::CORE_TAG_WIDTH-1:0]  tag;
    } core_req_t;

    // Read responses only
    typedef struct packed {
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]     data;
        logic [cache_cfg_pkg::CORE_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    ////////////////////////////////////////////////////////////
    // Memory side

    // Byte enable and data are line positioned
    typedef struct packed {
        logic                                      rw;
        logic [cache_cfg_pkg::LINE_ADDR_WIDTH-1:0] addr;
        logic [cache_cfg_pkg::LINE_SIZE-1:0]       byteen;
        logic [cache_cfg_pkg::LINE_WIDTH-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        logic [cache_cfg_pkg::LINE_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

/* src/cache_skid_buffer.sv */
module cache_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     valid_in,
    input  payload_t data_in,
    output logic     ready_in,

    output logic     valid_out,
    output payload_t data_out,
    input  logic     ready_out
);

    payload_t   entry_q [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    // Ready depends on local state only
    assign ready_in  = (count != 2'd2);
    assign valid_out = (count != 2'd0);
    assign data_out  = entry_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr] <= data_in;
        end
    end

endmodule

/* src/cache_tag_store.sv */
module cache_tag_store #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input  logic                                      clk,
    input  logic                                      flush_valid,
    input  logic [$clog2(NUM_LINES)-1:0]              flush_index,
    input  logic [cache_cfg_pkg::WORD_ADDR_WIDTH-1:0] lookup_addr,
    input  logic                                      fill_valid,
    output logic                                      hit
);

    import cache_cfg_pkg::*;

    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int TAG_W   = LINE_ADDR_WIDTH - INDEX_W;

    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [INDEX_W-1:0]   index;
    logic [TAG_W-1:0]     tag;

    assign index = INDEX_W'(addr_index(lookup_addr, NUM_LINES));
    assign tag   = TAG_W'(addr_tag(lookup_addr, NUM_LINES));

    // Flush wins over fill
    always_ff @(posedge clk) begin
        if (flush_valid) begin
            valid_q[flush_index] <= 1'b0;
        end else if (fill_valid) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[index] <= tag;
        end
    end

    assign hit = valid_q[index] && (tag_mem[index] == tag);

endmodule

/* src/cache_top.sv */
module cache_top #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     core_req_valid,
    input  cache_msg_pkg::core_req_t core_req,
    output logic                     core_req_ready,

    output logic                     core_rsp_valid,
    output cache_msg_pkg::core_rsp_t core_rsp,
    input  logic                     core_rsp_ready,

    output logic                     mem_req_valid,
    output cache_msg_pkg::mem_req_t  mem_req,
    input  logic                     mem_req_ready,

    input  logic                     mem_rsp_valid,
    input  cache_msg_pkg::mem_rsp_t  mem_rsp
);

    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;

    logic                         flush_valid;
    logic [$clog2(NUM_LINES)-1:0] flush_index;

    logic                         hit;
    logic [WORD_WIDTH-1:0]        read_word;
    logic                         fill_valid;
    logic [LINE_WIDTH-1:0]        fill_line;
    logic                         write_valid;
    logic [WORD_SIZE-1:0]         write_byteen;
    logic [WORD_WIDTH-1:0]        write_word;
    logic [WORD_ADDR_WIDTH-1:0]   lookup_addr;

    logic                         bank_rsp_valid;
    core_rsp_t                    bank_rsp;
    logic                         bank_rsp_ready;
    logic                         bank_mreq_valid;
    mem_req_t                     bank_mreq;
    logic                         bank_mreq_ready;

    ////////////////////////////////////////////////////////////

    cache_flush_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) flush_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .flush_valid (flush_valid),
        .flush_index (flush_index)
    );

    cache_tag_store #(
        .NUM_LINES (NUM_LINES)
    ) tag_store_i (
        .clk         (clk),
        .flush_valid (flush_valid),
        .flush_index (flush_index),
        .lookup_addr (lookup_addr),
        .fill_valid  (fill_valid),
        .hit         (hit)
    );

    cache_data_store #(
        .NUM_LINES (NUM_LINES)
    ) data_store_i (
        .clk         (clk),
        .addr        (lookup_addr),
        .fill_valid  (fill_valid),
        .fill_line   (fill_line),
        .write_valid (write_valid),
        .byteen      (write_byteen),
        .write_word  (write_word),
        .read_word   (read_word)
    );

    ////////////////////////////////////////////////////////////

    cache_bank_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) bank_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .flush_valid    (flush_valid),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .hit            (hit),
        .read_word      (read_word),
        .fill_valid     (fill_valid),
        .fill_line      (fill_line),
        .write_valid    (write_valid),
        .write_byteen   (write_byteen),
        .write_word     (write_word),
        .lookup_addr    (lookup_addr),
        .rsp_valid      (bank_rsp_valid),
        .rsp            (bank_rsp),
        .rsp_ready      (bank_rsp_ready),
        .mreq_valid     (bank_mreq_valid),
        .mreq           (bank_mreq),
        .mreq_ready     (bank_mreq_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp)
    );

    // Output stages toward memory and core
    cache_skid_buffer #(
        .payload_t (mem_req_t)
    ) mem_req_sbuf_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (bank_mreq_valid),
        .data_in   (bank_mreq),
        .ready_in  (bank_mreq_ready),
        .valid_out (mem_req_valid),
        .data_out  (mem_req),
        .ready_out (mem_req_ready)
    );

    cache_skid_buffer #(
        .payload_t (core_rsp_t)
    ) core_rsp_sbuf_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (bank_rsp_valid),
        .data_in   (bank_rsp),
        .ready_in  (bank_rsp_ready),
        .valid_out (core_rsp_valid),
        .data_out  (core_rsp),
        .ready_out (core_rsp_ready)
    );

endmodule

/* tb/cache_top_asserts.sv */
module cache_top_asserts #(
    parameter int NUM_LINES = cache_cfg_pkg::DEFAULT_NUM_LINES
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush_valid,
    input logic                     core_req_ready,
    input logic                     core_rsp_valid,
    input cache_msg_pkg::core_rsp_t core_rsp,
    input logic                     core_rsp_ready,
    input logic                     mem_req_valid,
    input cache_msg_pkg::mem_req_t  mem_req,
    input logic                     mem_req_ready
);

    // Saturating count of cycles since reset fell
    logic [7:0] since_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            since_reset <= '0;
        end else if (since_reset != 8'hff) begin
            since_reset <= since_reset + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////

    mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed while stalled");

    core_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core_rsp dropped or changed while stalled");

    ready_after_flush: assert property (@(posedge clk) disable iff (reset)
        core_req_ready |-> int'(since_reset) >= NUM_LINES)
        else $error("core_req_ready rose before the flush finished");

    no_mem_req_in_flush: assert property (@(posedge clk) disable iff (reset)
        flush_valid |-> !mem_req_valid)
        else $error("mem_req_valid high during the flush");

endmodule

bind cache_top cache_top_asserts #(
    .NUM_LINES (NUM_LINES)
) asserts_i (
    .clk            (clk),
    .reset          (reset),
    .flush_valid    (flush_valid),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp       (core_rsp),
    .core_rsp_ready (core_rsp_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready)
);

/* tb/cache_top_tb.sv */
module cache_top_tb;

    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;

    localparam int          NUM_LINES   = 16;
    localparam int          MEM_LINES   = 1 << LINE_ADDR_WIDTH;
    localparam logic [31:0] SEED        = 32'h240d_122f;
    localparam int          WAIT_LIMIT  = 200;
    localparam int          STRESS_OPS  = 400;
    localparam int          STRESS_BASE = 'h40;

    logic      clk;
    logic      reset;
    logic      core_req_valid;
    core_req_t core_req;
    logic      core_req_ready;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      core_rsp_ready;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    mem_rsp_t  mem_rsp;

    logic [LINE_WIDTH-1:0]      mem_lines [MEM_LINES];
    logic [LINE_WIDTH-1:0]      shadow [MEM_LINES];
    logic                       model_valid [NUM_LINES];
    logic [LINE_ADDR_WIDTH-1:0] model_line [NUM_LINES];
    core_rsp_t                  rsp_queue [$];
    mem_req_t                   mreq_queue [$];
    int                         mem_reads;
    logic [CORE_TAG_WIDTH-1:0]  next_tag;
    string                      test_name;

    cache_top #(
        .NUM_LINES (NUM_LINES)
    ) cache_top_i (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    // Odd multiplier keeps every word address distinct
    function automatic logic [LINE_WIDTH-1:0] line_pattern(input int line_addr);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w * WORD_WIDTH +: WORD_WIDTH] =
                (32'h9e37_79b9 * 32'(line_addr * WORDS_PER_LINE + w + 1)) ^ SEED;
        end
        return line;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] expected_word(
        input logic [WORD_ADDR_WIDTH-1:0] addr,
        input logic [LINE_WIDTH-1:0]      lines [MEM_LINES]
    );
        logic [LINE_WIDTH-1:0] line;
        line = lines[addr_line(addr)];
        return line[addr_word_sel(addr) * WORD_WIDTH +: WORD_WIDTH];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic record_accept(input core_req_t req);
        mem_req_t                   exp_m;
        core_rsp_t                  exp_r;
        logic [LINE_ADDR_WIDTH-1:0] line;
        int                         idx;
        int                         wsel;
        line       = addr_line(req.addr);
        idx        = int'(addr_index(req.addr, NUM_LINES));
        wsel       = int'(addr_word_sel(req.addr));
        exp_m      = '0;
        exp_m.rw   = req.rw;
        exp_m.addr = line;
        if (req.rw) begin
            exp_m.byteen[wsel * WORD_SIZE +: WORD_SIZE]  = req.byteen;
            exp_m.data[wsel * WORD_WIDTH +: WORD_WIDTH] = req.data;
            mreq_queue.push_back(exp_m);
            for (int b = 0; b < WORD_SIZE; b++) begin
                if (req.byteen[b]) begin
                    shadow[line][wsel * WORD_WIDTH + b * 8 +: 8] = req.data[b * 8 +: 8];
                end
            end
        end else begin
            exp_r.data = expected_word(req.addr, shadow);
            exp_r.tag  = req.tag;
            rsp_queue.push_back(exp_r);
            // Only reads move the tags, writes never allocate
            if (!(model_valid[idx] && model_line[idx] == line)) begin
                mreq_queue.push_back(exp_m);
                model_valid[idx] = 1'b1;
                model_line[idx]  = line;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic issue_request(
        input logic                       rw,
        input logic [WORD_ADDR_WIDTH-1:0] addr,
        input logic [WORD_SIZE-1:0]       byteen,
        input logic [WORD_WIDTH-1:0]      data
    );
        core_req_t req;
        int        waited;
        req    = '{rw: rw, addr: addr, byteen: byteen, data: data, tag: next_tag};
        waited = 0;
        @(negedge clk);
        core_req_valid = 1'b1;
        core_req       = req;
        #1;
        while (!core_req_ready) begin
            waited++;
            assert (waited < WAIT_LIMIT)
                else fail_now($sformatf("%s: core request was never accepted", test_name));
            @(negedge clk);
            #1;
        end
        record_accept(req);
        next_tag = next_tag + 1'b1;
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rsp_queue.size() != 0 || mreq_queue.size() != 0) begin
            waited++;
            assert (waited < WAIT_LIMIT * 4)
                else fail_now($sformatf("%s: responses or memory requests still missing",
                                        test_name));
            @(negedge clk);
        end
        // A few idle cycles to catch stray requests
        repeat (4) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model

    initial begin : memory_model
        mem_req_t                   req;
        mem_req_t                   exp;
        logic [LINE_WIDTH-1:0]      mask;
        logic [LINE_ADDR_WIDTH-1:0] rd_addr;
        logic                       rd_pending;
        int                         rsp_delay;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        rd_pending    = 1'b0;
        rd_addr       = '0;
        rsp_delay     = 0;
        mem_reads     = 0;
        for (int i = 0; i < MEM_LINES; i++) begin
            mem_lines[i] = line_pattern(i);
        end
        forever begin
            @(negedge clk);
            mem_rsp_valid = 1'b0;
            if (rd_pending) begin
                if (rsp_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.data  = mem_lines[rd_addr];
                    rd_pending    = 1'b0;
                end else begin
                    rsp_delay--;
                end
            end
            mem_req_ready = !rd_pending && ($urandom % 4 != 0);
            #1;
            if (mem_req_valid && mem_req_ready) begin
                req = mem_req;
                assert (mreq_queue.size() != 0)
                    else fail_now($sformatf("%s: memory request with none expected", test_name));
                exp  = mreq_queue.pop_front();
                mask = '0;
                for (int b = 0; b < LINE_SIZE; b++) begin
                    if (exp.byteen[b]) begin
                        mask[b * 8 +: 8] = 8'hff;
                    end
                end
                assert (req.rw == exp.rw && req.addr == exp.addr && req.byteen == exp.byteen
                        && (req.data & mask) == (exp.data & mask))
                    else fail_now($sformatf(
                        "error %s: mem_req expected rw %0b addr %h byteen %h data %h %s",
                        test_name, exp.rw, exp.addr, exp.byteen, exp.data & mask,
                        $sformatf("actual rw %0b addr %h byteen %h data %h",
                                  req.rw, req.addr, req.byteen, req.data & mask)));
                if (req.rw) begin
                    for (int b = 0; b < LINE_SIZE; b++) begin
                        if (req.byteen[b]) begin
                            mem_lines[req.addr][b * 8 +: 8] = req.data[b * 8 +: 8];
                        end
                    end
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = req.addr;
                    rsp_delay  = int'($urandom % 6);
                    mem_reads++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Response compare

    initial begin : response_compare
        core_rsp_t exp;
        core_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            core_rsp_ready = ($urandom % 4 != 0);
            #1;
            if (core_rsp_valid && core_rsp_ready) begin
                assert (rsp_queue.size() != 0)
                    else fail_now($sformatf("%s: core response with no read outstanding",
                                            test_name));
                exp = rsp_queue.pop_front();
                assert (core_rsp == exp)
                    else fail_now($sformatf("error %s: core_rsp expected %h actual %h",
                                            test_name, exp, core_rsp));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : main_sequence
        logic [LINE_ADDR_WIDTH-1:0] stress_line;
        logic [WORD_ADDR_WIDTH-1:0] addr;
        int                         reads_before;
        void'($urandom(SEED));
        reset          = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        next_tag       = '0;
        test_name      = "reset";
        for (int i = 0; i < MEM_LINES; i++) begin
            shadow[i] = line_pattern(i);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_line[i]  = '0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_name = "flush";
        for (int i = 0; i < NUM_LINES; i++) begin
            #1;
            assert (!core_req_ready)
                else fail_now("flush: core_req_ready rose before every line was invalidated");
            @(negedge clk);
        end
        issue_request(1'b0, 14'h0123, 4'h0, 32'h0);
        wait_drain();

        test_name    = "miss_then_hit";
        reads_before = mem_reads;
        issue_request(1'b0, 14'h0200, 4'h0, 32'h0);
        issue_request(1'b0, 14'h0203, 4'h0, 32'h0);
        issue_request(1'b0, 14'h0122, 4'h0, 32'h0);
        wait_drain();
        assert (mem_reads - reads_before == 1)
            else fail_now($sformatf("error %s: memory reads expected 1 actual %0d",
                                    test_name, mem_reads - reads_before));

        test_name = "write_through";
        issue_request(1'b1, 14'h0201, 4'b0101, 32'ha5a5_5a5a);
        issue_request(1'b1, 14'h0122, 4'b1000, 32'h1234_5678);
        issue_request(1'b1, 14'h1f00, 4'b1111, 32'hdead_beef);
        issue_request(1'b0, 14'h0201, 4'h0, 32'h0);
        issue_request(1'b0, 14'h0122, 4'h0, 32'h0);
        issue_request(1'b0, 14'h1f00, 4'h0, 32'h0);
        wait_drain();

        // Same index with tags one apart
        test_name    = "conflict";
        reads_before = mem_reads;
        for (int i = 0; i < 4; i++) begin
            issue_request(1'b0, 14'h0310, 4'h0, 32'h0);
            issue_request(1'b0, 14'(14'h0310 + NUM_LINES * WORDS_PER_LINE), 4'h0, 32'h0);
        end
        wait_drain();
        assert (mem_reads - reads_before == 8)
            else fail_now($sformatf("error %s: memory reads expected 8 actual %0d",
                                    test_name, mem_reads - reads_before));

        test_name = "stress";
        for (int i = 0; i < STRESS_OPS; i++) begin
            stress_line = LINE_ADDR_WIDTH'(STRESS_BASE + int'($urandom % 2) * NUM_LINES
                                           + int'($urandom % 4));
            addr        = {stress_line, WORD_SEL_BITS'($urandom % WORDS_PER_LINE)};
            issue_request(1'($urandom % 2), addr, 4'($urandom % 16), $urandom);
        end
        wait_drain();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verilog.f */
src/cache_cfg_pkg.sv
src/cache_msg_pkg.sv
src/cache_flush_ctrl.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/cache_skid_buffer.sv
src/cache_bank_ctrl.sv
src/cache_top.sv
tb/cache_top_asserts.sv
tb/cache_top_tb.sv
